// File: include/sketch_pad_cfg.svh
`ifndef SKETCH_PAD_CFG_SVH
`define SKETCH_PAD_CFG_SVH

// Drawing grid geometry
`define SKETCH_GRID_CELLS 28
`define SKETCH_CELL_SHIFT 4
`define SKETCH_AREA_PIX 448

// 784 cells packed into 32-bit words
`define SKETCH_CANVAS_WORDS 25

// 640x480 timing in pixels and lines
`define SKETCH_H_VISIBLE 640
`define SKETCH_H_FRONT 16
`define SKETCH_H_SYNC 96
`define SKETCH_H_TOTAL 800
`define SKETCH_V_VISIBLE 480
`define SKETCH_V_FRONT 10
`define SKETCH_V_SYNC 2
`define SKETCH_V_TOTAL 525

// Control register for the classifier port
`define SKETCH_CLEAR_ADDR 12'h080

`endif

// File: source/canvas_pkg.sv
`include "sketch_pad_cfg.svh"

package canvas_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [4:0] cell_t;
    typedef logic [9:0] cell_index_t;
    typedef logic [`SKETCH_GRID_CELLS*`SKETCH_GRID_CELLS-1:0] canvas_t;
    typedef logic signed [8:0] move_t;
    typedef logic [4:0] word_index_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb4_t;

    localparam rgb4_t RGB_BLACK = 12'h000;
    localparam rgb4_t RGB_WHITE = 12'hfff;
    localparam rgb4_t RGB_GRAY = 12'h888;

endpackage

// File: source/axil_pkg.sv
package axil_pkg;

    // Byte address on the classifier port
    typedef logic [11:0] addr_t;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

// File: source/ps2_mouse_rx.sv
module ps2_mouse_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic               mouse_clk,
    input  logic               mouse_data,
    output logic               pkt_valid,
    output canvas_pkg::move_t  pkt_dx,
    output canvas_pkg::move_t  pkt_dy,
    output logic               pkt_left
);

    // Two sync stages plus one for edge detection
    logic [2:0] mclk_pipe;
    logic [1:0] mdat_pipe;
    logic       fall;
    logic       mdat;
    logic [3:0] bit_cnt;
    logic [8:0] shreg;
    logic [1:0] byte_cnt;
    logic [7:0] status;
    logic [7:0] x_low;
    logic       frame_ok;
    logic       byte_done;

    assign fall = mclk_pipe[2] & ~mclk_pipe[1];
    assign mdat = mdat_pipe[1];

    // shreg holds parity in bit 8 and data in bits 7..0 at the stop bit
    assign frame_ok = (^shreg) & mdat;
    assign byte_done = fall && (bit_cnt == 4'd10) && frame_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            mclk_pipe <= '1;
            mdat_pipe <= '1;
            bit_cnt <= '0;
            byte_cnt <= '0;
            pkt_valid <= 1'b0;
        end else begin
            mclk_pipe <= {mclk_pipe[1:0], mouse_clk};
            mdat_pipe <= {mdat_pipe[0], mouse_data};
            pkt_valid <= 1'b0;
            if (fall) begin
                if (bit_cnt == 4'd0) begin
                    // Wait for a low start bit
                    if (!mdat) bit_cnt <= 4'd1;
                end else if (bit_cnt < 4'd10) begin
                    bit_cnt <= bit_cnt + 4'd1;
                end else begin
                    bit_cnt <= 4'd0;
                    if (!frame_ok) begin
                        byte_cnt <= 2'd0;
                    end else if (byte_cnt == 2'd0) begin
                        // Bit 3 is always set in a real status byte
                        if (shreg[3]) byte_cnt <= 2'd1;
                    end else if (byte_cnt == 2'd1) begin
                        byte_cnt <= 2'd2;
                    end else begin
                        byte_cnt <= 2'd0;
                        pkt_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall && bit_cnt != 4'd0 && bit_cnt < 4'd10) shreg <= {mdat, shreg[8:1]};
        if (byte_done && byte_cnt == 2'd0) status <= shreg[7:0];
        if (byte_done && byte_cnt == 2'd1) x_low <= shreg[7:0];
        if (byte_done && byte_cnt == 2'd2) begin
            pkt_dx <= {status[4], x_low};
            pkt_dy <= {status[5], shreg[7:0]};
            pkt_left <= status[0];
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (rst)
        pkt_valid |=> !pkt_valid);

endmodule

// File: source/cursor_canvas.sv
`include "sketch_pad_cfg.svh"

module cursor_canvas (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pkt_valid,
    input  canvas_pkg::move_t        pkt_dx,
    input  canvas_pkg::move_t        pkt_dy,
    input  logic                     pkt_left,
    input  logic                     clear_req,
    input  canvas_pkg::cell_index_t  disp_index,
    input  canvas_pkg::word_index_t  word_index,
    output logic                     disp_bit,
    output logic [31:0]              word_data
);

    canvas_pkg::coord_t      cur_x;
    canvas_pkg::coord_t      cur_y;
    canvas_pkg::coord_t      new_x;
    canvas_pkg::coord_t      new_y;
    canvas_pkg::cell_t       paint_col;
    canvas_pkg::cell_t       paint_row;
    canvas_pkg::cell_index_t paint_index;
    canvas_pkg::canvas_t     canvas;
    logic signed [11:0]      sum_x;
    logic signed [11:0]      sum_y;
    logic [`SKETCH_CANVAS_WORDS*32-1:0] padded;

    function automatic canvas_pkg::coord_t clamp_area(input logic signed [11:0] v);
        if (v < 0) return '0;
        if (v > `SKETCH_AREA_PIX - 1) return canvas_pkg::coord_t'(`SKETCH_AREA_PIX - 1);
        return v[9:0];
    endfunction

    // Screen y grows downward while PS/2 y grows upward
    assign sum_x = $signed({2'b00, cur_x}) + $signed({{3{pkt_dx[8]}}, pkt_dx});
    assign sum_y = $signed({2'b00, cur_y}) - $signed({{3{pkt_dy[8]}}, pkt_dy});
    assign new_x = clamp_area(sum_x);
    assign new_y = clamp_area(sum_y);

    assign paint_col = canvas_pkg::cell_t'(new_x >> `SKETCH_CELL_SHIFT);
    assign paint_row = canvas_pkg::cell_t'(new_y >> `SKETCH_CELL_SHIFT);
    assign paint_index = canvas_pkg::cell_index_t'(paint_row * `SKETCH_GRID_CELLS + paint_col);

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_x <= canvas_pkg::coord_t'(`SKETCH_AREA_PIX / 2);
            cur_y <= canvas_pkg::coord_t'(`SKETCH_AREA_PIX / 2);
            canvas <= '0;
        end else begin
            if (pkt_valid) begin
                cur_x <= new_x;
                cur_y <= new_y;
            end
            // Clear overrides a paint in the same cycle
            if (clear_req) canvas <= '0;
            else if (pkt_valid && pkt_left) canvas[paint_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_index < $bits(canvas_pkg::canvas_t)) disp_bit <= canvas[disp_index];
        else disp_bit <= 1'b0;
    end

    // Last word carries 16 unused bits
    assign padded = ($bits(padded))'(canvas);
    assign word_data = (word_index < `SKETCH_CANVAS_WORDS) ? padded[word_index*32 +: 32] : '0;

    a_cursor_in_area: assert property (@(posedge clk) disable iff (rst)
        cur_x < `SKETCH_AREA_PIX && cur_y < `SKETCH_AREA_PIX);

    a_tail_zero: assert property (@(posedge clk) disable iff (rst)
        (word_index == 5'd24) |-> (word_data[31:16] == 16'h0000));

endmodule

// File: source/vga_scan_out.sv
`include "sketch_pad_cfg.svh"

module vga_scan_out (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     disp_bit,
    output canvas_pkg::cell_index_t  disp_index,
    output canvas_pkg::rgb4_t        vga_rgb,
    output logic                     vga_hs,
    output logic                     vga_vs
);

    localparam int H_SYNC_START = `SKETCH_H_VISIBLE + `SKETCH_H_FRONT;
    localparam int V_SYNC_START = `SKETCH_V_VISIBLE + `SKETCH_V_FRONT;

    canvas_pkg::coord_t h_cnt;
    canvas_pkg::coord_t v_cnt;
    logic               hs1;
    logic               vs1;
    logic               vis1;
    logic               area1;

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == `SKETCH_H_TOTAL - 1) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == `SKETCH_V_TOTAL - 1) ? '0 : v_cnt + 10'd1;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    // Cell lookup, the canvas answers one cycle later
    assign disp_index = canvas_pkg::cell_index_t'((v_cnt >> `SKETCH_CELL_SHIFT) * `SKETCH_GRID_CELLS
                                                  + (h_cnt >> `SKETCH_CELL_SHIFT));

    always_ff @(posedge clk) begin
        if (rst) begin
            hs1 <= 1'b1;
            vs1 <= 1'b1;
            vis1 <= 1'b0;
            area1 <= 1'b0;
            vga_hs <= 1'b1;
            vga_vs <= 1'b1;
            vga_rgb <= canvas_pkg::RGB_BLACK;
        end else begin
            hs1 <= !(h_cnt >= H_SYNC_START && h_cnt < H_SYNC_START + `SKETCH_H_SYNC);
            vs1 <= !(v_cnt >= V_SYNC_START && v_cnt < V_SYNC_START + `SKETCH_V_SYNC);
            vis1 <= (h_cnt < `SKETCH_H_VISIBLE) && (v_cnt < `SKETCH_V_VISIBLE);
            area1 <= (h_cnt < `SKETCH_AREA_PIX) && (v_cnt < `SKETCH_AREA_PIX);

            // Second stage meets disp_bit
            vga_hs <= hs1;
            vga_vs <= vs1;
            if (!vis1) vga_rgb <= canvas_pkg::RGB_BLACK;
            else if (!area1) vga_rgb <= canvas_pkg::RGB_GRAY;
            else if (disp_bit) vga_rgb <= canvas_pkg::RGB_BLACK;
            else vga_rgb <= canvas_pkg::RGB_WHITE;
        end
    end

endmodule

// File: source/canvas_axil_slave.sv
`include "sketch_pad_cfg.svh"

module canvas_axil_slave (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     awvalid,
    input  axil_pkg::addr_t          awaddr,
    input  logic                     wvalid,
    input  logic [31:0]              wdata,
    input  logic                     bready,
    input  logic                     arvalid,
    input  axil_pkg::addr_t          araddr,
    input  logic                     rready,
    input  logic [31:0]              word_data,
    output logic                     awready,
    output logic                     wready,
    output logic                     bvalid,
    output axil_pkg::resp_t          bresp,
    output logic                     arready,
    output logic                     rvalid,
    output logic [31:0]              rdata,
    output axil_pkg::resp_t          rresp,
    output canvas_pkg::word_index_t  word_index,
    output logic                     clear_req
);

    logic rd_go;
    logic rd_ok;
    logic wr_go;
    logic wr_clear;

    assign arready = !rvalid;
    assign rd_go = arvalid && arready;
    assign word_index = araddr[6:2];
    assign rd_ok = (araddr[1:0] == 2'b00) && (araddr < `SKETCH_CANVAS_WORDS * 4);

    // Address and data are only taken as a pair
    assign awready = !bvalid && (awvalid == wvalid);
    assign wready = awready;
    assign wr_go = awvalid && wvalid && !bvalid;

    // The data word carries no meaning for the clear command
    assign wr_clear = (awaddr == `SKETCH_CLEAR_ADDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            clear_req <= 1'b0;
        end else begin
            clear_req <= wr_go && wr_clear;
            if (rd_go) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
            if (wr_go) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            rdata <= rd_ok ? word_data : 32'h0;
            rresp <= rd_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
        if (wr_go) bresp <= wr_clear ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
    end

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// File: source/sketch_pad.sv
module sketch_pad (
    input  logic               clk,
    input  logic               rst,
    input  logic               mouse_clk,
    input  logic               mouse_data,
    input  logic               awvalid,
    input  axil_pkg::addr_t    awaddr,
    input  logic               wvalid,
    input  logic [31:0]        wdata,
    input  logic               bready,
    input  logic               arvalid,
    input  axil_pkg::addr_t    araddr,
    input  logic               rready,
    output logic               awready,
    output logic               wready,
    output logic               bvalid,
    output axil_pkg::resp_t    bresp,
    output logic               arready,
    output logic               rvalid,
    output logic [31:0]        rdata,
    output axil_pkg::resp_t    rresp,
    output canvas_pkg::rgb4_t  vga_rgb,
    output logic               vga_hs,
    output logic               vga_vs
);

    logic                    pkt_valid;
    canvas_pkg::move_t       pkt_dx;
    canvas_pkg::move_t       pkt_dy;
    logic                    pkt_left;
    logic                    clear_req;
    canvas_pkg::cell_index_t disp_index;
    logic                    disp_bit;
    canvas_pkg::word_index_t word_index;
    logic [31:0]             word_data;

    ps2_mouse_rx u_rx (
        .clk, .rst, .mouse_clk, .mouse_data,
        .pkt_valid, .pkt_dx, .pkt_dy, .pkt_left
    );

    cursor_canvas u_canvas (
        .clk, .rst, .pkt_valid, .pkt_dx, .pkt_dy, .pkt_left, .clear_req,
        .disp_index, .word_index, .disp_bit, .word_data
    );

    vga_scan_out u_vga (
        .clk, .rst, .disp_bit, .disp_index, .vga_rgb, .vga_hs, .vga_vs
    );

    canvas_axil_slave u_axil (
        .clk, .rst, .awvalid, .awaddr, .wvalid, .wdata, .bready,
        .arvalid, .araddr, .rready, .word_data,
        .awready, .wready, .bvalid, .bresp, .arready, .rvalid, .rdata, .rresp,
        .word_index, .clear_req
    );

endmodule

// File: sim/sketch_pad_checker.sv
`include "sketch_pad_cfg.svh"

module sketch_pad_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              arvalid,
    input  logic              arready,
    input  axil_pkg::addr_t   araddr,
    input  logic              rvalid,
    input  logic              rready,
    input  logic [31:0]       rdata,
    input  axil_pkg::resp_t   rresp,
    input  logic              awvalid,
    input  logic              awready,
    input  axil_pkg::addr_t   awaddr,
    input  logic              wready,
    input  logic              bvalid,
    input  logic              bready,
    input  axil_pkg::resp_t   bresp,
    input  logic [11:0]       vga_rgb,
    input  logic              vga_hs,
    input  logic              vga_vs,
    input  logic              ev_pkt,
    input  canvas_pkg::move_t ev_dx,
    input  canvas_pkg::move_t ev_dy,
    input  logic              ev_left,
    input  axil_pkg::resp_t   exp_resp,
    input  logic [127:0]      step_name,
    input  logic              chk_frame,
    output int                value_errs,
    output int                other_errs,
    output int                pix_cnt,
    output logic              locked
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CELLS = `SKETCH_GRID_CELLS * `SKETCH_GRID_CELLS;
    localparam int H_SYNC_START = `SKETCH_H_VISIBLE + `SKETCH_H_FRONT;
    localparam int V_SYNC_START = `SKETCH_V_VISIBLE + `SKETCH_V_FRONT;

    canvas_pkg::canvas_t model;
    int              cur_x;
    int              cur_y;
    int              hpos;
    int              vpos;
    int              hs_low;
    int              vs_low;
    logic            h_lock;
    logic            v_lock;
    axil_pkg::addr_t rd_addr;
    logic            prev_rvalid;
    logic            prev_rready;
    logic            prev_bvalid;
    logic            prev_bready;
    logic            prev_hs;
    logic            prev_vs;
    logic [31:0]     prev_rdata;
    axil_pkg::resp_t prev_rresp;
    axil_pkg::resp_t prev_bresp;

    assign locked = h_lock && v_lock;

    function automatic int clamp_area(input int v);
        if (v < 0) return 0;
        if (v > `SKETCH_AREA_PIX - 1) return `SKETCH_AREA_PIX - 1;
        return v;
    endfunction

    function automatic logic [31:0] model_word(input int w);
        logic [31:0] wd;
        int          c;
        wd = '0;
        for (int i = 0; i < 32; i++) begin
            c = w * 32 + i;
            if (c < CELLS) wd[i] = model[c];
        end
        return wd;
    endfunction

    // Colour of an output pixel at screen position (h, v)
    function automatic logic [11:0] model_colour(input int h, input int v);
        if (h >= `SKETCH_H_VISIBLE || v >= `SKETCH_V_VISIBLE) return 12'h000;
        if (h >= `SKETCH_AREA_PIX || v >= `SKETCH_AREA_PIX) return 12'h888;
        if (model[(v >> `SKETCH_CELL_SHIFT) * `SKETCH_GRID_CELLS + (h >> `SKETCH_CELL_SHIFT)])
            return 12'h000;
        return 12'hfff;
    endfunction

    task automatic value_err(input logic [127:0] name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        value_errs++;
        if (value_errs <= 20) $display("ERR %0s expected %h actual %h", name, exp_v, act_v);
    endtask

    task automatic other_err(input string what);
        other_errs++;
        if (other_errs <= 20) $display("%0s (step %0s)", what, step_name);
    endtask

    always @(posedge clk) begin
        int          nx;
        int          ny;
        logic        rd_ok;
        logic [31:0] exp_data;
        logic [11:0] exp_rgb;
        if (rst) begin
            model = '0;
            cur_x = `SKETCH_AREA_PIX / 2;
            cur_y = `SKETCH_AREA_PIX / 2;
            h_lock = 1'b0;
            v_lock = 1'b0;
            hpos = 0;
            vpos = 0;
            hs_low = 0;
            vs_low = 0;
            value_errs = 0;
            other_errs = 0;
            pix_cnt = 0;
        end else begin
            // Cursor and paint model, PS/2 y counts upward
            if (ev_pkt) begin
                nx = clamp_area(cur_x + int'(ev_dx));
                ny = clamp_area(cur_y - int'(ev_dy));
                cur_x = nx;
                cur_y = ny;
                if (ev_left)
                    model[(ny >> `SKETCH_CELL_SHIFT) * `SKETCH_GRID_CELLS
                          + (nx >> `SKETCH_CELL_SHIFT)] = 1'b1;
            end

            if (arvalid && arready) rd_addr = araddr;
            if (rvalid && rready) begin
                rd_ok = (rd_addr[1:0] == 2'b00) && (rd_addr < `SKETCH_CANVAS_WORDS * 4);
                exp_data = rd_ok ? model_word(rd_addr >> 2) : 32'h0;
                if (rdata !== exp_data) value_err(step_name, exp_data, rdata);
                if (rresp !== exp_resp) value_err(step_name, exp_resp, rresp);
            end
            if (awvalid && awready && awaddr == `SKETCH_CLEAR_ADDR) model = '0;
            if (bvalid && bready && bresp !== exp_resp) value_err(step_name, exp_resp, bresp);

            // Ready outputs against pending responses
            if (rvalid && arready)
                other_err("arready was high while a read response was pending");
            if (bvalid && (awready || wready))
                other_err("awready or wready was high while a write response was pending");
            if (awvalid && awready !== wready)
                other_err("write address and data were not accepted together");

            // Responses held under back-pressure
            if (prev_rvalid && !prev_rready
                && (!rvalid || rdata !== prev_rdata || rresp !== prev_rresp))
                other_err("read response changed while rready was low");
            if (prev_bvalid && !prev_bready && (!bvalid || bresp !== prev_bresp))
                other_err("write response changed while bready was low");

            // Screen position, locked to the sync falling edges
            hpos = (hpos == `SKETCH_H_TOTAL - 1) ? 0 : hpos + 1;
            if (hpos == 0) vpos = (vpos == `SKETCH_V_TOTAL - 1) ? 0 : vpos + 1;
            if (prev_hs && !vga_hs) begin
                if (h_lock && hpos != H_SYNC_START) other_err("hsync fell at the wrong pixel");
                hpos = H_SYNC_START;
                h_lock = 1'b1;
            end
            if (prev_vs && !vga_vs) begin
                if (v_lock && vpos != V_SYNC_START) other_err("vsync fell on the wrong line");
                vpos = V_SYNC_START;
                v_lock = 1'b1;
            end

            if (!vga_hs) begin
                hs_low++;
            end else if (!prev_hs) begin
                if (hs_low != `SKETCH_H_SYNC) value_err("hsync_width", `SKETCH_H_SYNC, hs_low);
                hs_low = 0;
            end
            if (!vga_vs) begin
                vs_low++;
            end else if (!prev_vs) begin
                if (vs_low != `SKETCH_V_SYNC * `SKETCH_H_TOTAL)
                    value_err("vsync_width", `SKETCH_V_SYNC * `SKETCH_H_TOTAL, vs_low);
                vs_low = 0;
            end

            if (chk_frame && locked) begin
                exp_rgb = model_colour(hpos, vpos);
                if (vga_rgb !== exp_rgb) value_err(step_name, exp_rgb, vga_rgb);
                if (hpos < `SKETCH_H_VISIBLE && vpos < `SKETCH_V_VISIBLE) pix_cnt++;
            end
        end
        prev_rvalid <= rvalid;
        prev_rready <= rready;
        prev_rdata <= rdata;
        prev_rresp <= rresp;
        prev_bvalid <= bvalid;
        prev_bready <= bready;
        prev_bresp <= bresp;
        prev_hs <= rst ? 1'b1 : vga_hs;
        prev_vs <= rst ? 1'b1 : vga_vs;
    end

endmodule

// File: sim/sketch_pad_tb.sv
`include "sketch_pad_cfg.svh"

module sketch_pad_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int K_PKT = 0;
    localparam int K_BADPAR = 1;
    localparam int K_BADHDR = 2;
    localparam int K_AXRD = 3;
    localparam int K_AXWR = 4;
    localparam int K_SWEEP = 5;
    localparam int K_FRAME = 6;
    localparam int MAX_ROWS = 32;
    localparam int FRAME_CYCLES = `SKETCH_H_TOTAL * `SKETCH_V_TOTAL;
    localparam int ROW_BUDGET = 4000;

    typedef struct {
        int              kind;
        int              dx;
        int              dy;
        logic            left;
        logic            rnd;
        axil_pkg::addr_t addr;
        axil_pkg::resp_t resp;
        int              stall;
        logic [127:0]    name;
    } step_t;

    logic               clk;
    logic               rst;
    logic               mouse_clk;
    logic               mouse_data;
    logic               awvalid;
    axil_pkg::addr_t    awaddr;
    logic               wvalid;
    logic [31:0]        wdata;
    logic               bready;
    logic               arvalid;
    axil_pkg::addr_t    araddr;
    logic               rready;
    logic               awready;
    logic               wready;
    logic               bvalid;
    axil_pkg::resp_t    bresp;
    logic               arready;
    logic               rvalid;
    logic [31:0]        rdata;
    axil_pkg::resp_t    rresp;
    canvas_pkg::rgb4_t  vga_rgb;
    logic               vga_hs;
    logic               vga_vs;

    logic               ev_pkt;
    canvas_pkg::move_t  ev_dx;
    canvas_pkg::move_t  ev_dy;
    logic               ev_left;
    axil_pkg::resp_t    exp_resp;
    logic [127:0]       step_name;
    logic               chk_frame;
    int                 value_errs;
    int                 other_errs;
    int                 pix_cnt;
    logic               locked;

    step_t steps[MAX_ROWS];
    int    n_rows;
    int    cycles;
    int    limit;
    int    tb_errs;

    sketch_pad DUT (
        .clk, .rst, .mouse_clk, .mouse_data,
        .awvalid, .awaddr, .wvalid, .wdata, .bready, .arvalid, .araddr, .rready,
        .awready, .wready, .bvalid, .bresp, .arready, .rvalid, .rdata, .rresp,
        .vga_rgb, .vga_hs, .vga_vs
    );

    sketch_pad_checker u_checker (
        .clk, .rst, .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .awvalid, .awready, .awaddr, .wready, .bvalid, .bready, .bresp,
        .vga_rgb(vga_rgb), .vga_hs, .vga_vs,
        .ev_pkt, .ev_dx, .ev_dy, .ev_left, .exp_resp, .step_name, .chk_frame,
        .value_errs, .other_errs, .pix_cnt, .locked
    );

    always #50 clk = ~clk;

    // Run limit from the table length plus two frames
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic wait_clk();
        @(posedge clk);
        #10;
    endtask

    task automatic add_row(input int kind, input int dx, input int dy, input logic left,
                           input logic rnd, input axil_pkg::addr_t addr,
                           input axil_pkg::resp_t resp, input int stall,
                           input logic [127:0] name);
        steps[n_rows].kind = kind;
        steps[n_rows].dx = dx;
        steps[n_rows].dy = dy;
        steps[n_rows].left = left;
        steps[n_rows].rnd = rnd;
        steps[n_rows].addr = addr;
        steps[n_rows].resp = resp;
        steps[n_rows].stall = stall;
        steps[n_rows].name = name;
        n_rows++;
    endtask

    // One PS/2 bit, sampled by the DUT on the falling mouse_clk
    task automatic send_bit(input logic b);
        mouse_data = b;
        repeat (4) wait_clk();
        mouse_clk = 1'b0;
        repeat (4) wait_clk();
        mouse_clk = 1'b1;
    endtask

    task automatic send_byte(input logic [7:0] d, input logic bad_par);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) send_bit(d[i]);
        // Odd parity, inverted for a corrupt frame
        send_bit(bad_par ? ^d : ~^d);
        send_bit(1'b1);
    endtask

    task automatic send_packet(input canvas_pkg::move_t dx, input canvas_pkg::move_t dy,
                               input logic left, input logic hdr_ok, input logic bad_par);
        logic [7:0] status;
        status = {2'b00, dy[8], dx[8], hdr_ok, 2'b00, left};
        send_byte(status, bad_par);
        send_byte(dx[7:0], 1'b0);
        send_byte(dy[7:0], 1'b0);
        repeat (8) wait_clk();
    endtask

    task automatic axi_read(input axil_pkg::addr_t addr, input int stall);
        logic ok;
        araddr = addr;
        arvalid = 1'b1;
        do begin
            ok = arready;
            wait_clk();
        end while (!ok);
        arvalid = 1'b0;
        repeat (stall) wait_clk();
        rready = 1'b1;
        do begin
            ok = rvalid;
            wait_clk();
        end while (!ok);
        rready = 1'b0;
    endtask

    task automatic axi_write(input axil_pkg::addr_t addr, input logic [31:0] data,
                             input int stall);
        logic ok;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        do begin
            ok = awready;
            wait_clk();
        end while (!ok);
        awvalid = 1'b0;
        wvalid = 1'b0;
        repeat (stall) wait_clk();
        bready = 1'b1;
        do begin
            ok = bvalid;
            wait_clk();
        end while (!ok);
        bready = 1'b0;
        repeat (3) wait_clk();
    endtask

    task automatic apply_row(input step_t s);
        step_name = s.name;
        exp_resp = s.resp;
        case (s.kind)
            K_PKT: begin
                send_packet(s.dx, s.dy, s.left, 1'b1, 1'b0);
                ev_dx = s.dx;
                ev_dy = s.dy;
                ev_left = s.left;
                ev_pkt = 1'b1;
                wait_clk();
                ev_pkt = 1'b0;
            end
            K_BADPAR: send_packet(s.dx, s.dy, s.left, 1'b1, 1'b1);
            K_BADHDR: send_packet(s.dx, s.dy, s.left, 1'b0, 1'b0);
            K_AXRD: axi_read(s.addr, s.stall);
            K_AXWR: axi_write(s.addr, 32'h5a5a_0001, s.stall);
            K_SWEEP: begin
                for (int w = 0; w < `SKETCH_CANVAS_WORDS; w++)
                    axi_read(axil_pkg::addr_t'(w * 4), (w == 0) ? s.stall : 0);
            end
            default: begin
                while (!locked) wait_clk();
                chk_frame = 1'b1;
                repeat (FRAME_CYCLES) wait_clk();
                chk_frame = 1'b0;
                if (pix_cnt != `SKETCH_H_VISIBLE * `SKETCH_V_VISIBLE) begin
                    tb_errs++;
                    $display("Frame check covered %0d visible pixels instead of a full frame",
                             pix_cnt);
                end
            end
        endcase
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        mouse_clk = 1'b1;
        mouse_data = 1'b1;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        ev_pkt = 1'b0;
        ev_dx = '0;
        ev_dy = '0;
        ev_left = 1'b0;
        exp_resp = axil_pkg::RESP_OKAY;
        step_name = "reset";
        chk_frame = 1'b0;
        cycles = 0;
        limit = 0;
        tb_errs = 0;
        n_rows = 0;
        void'($urandom(4));

        // Bad rows keep bit 3 clear in both movement bytes
        add_row(K_PKT, 0, 0, 1, 0, 0, axil_pkg::RESP_OKAY, 0, "paint_center");
        add_row(K_PKT, 255, 0, 1, 0, 0, axil_pkg::RESP_OKAY, 0, "clamp_right");
        add_row(K_PKT, -256, -256, 1, 0, 0, axil_pkg::RESP_OKAY, 0, "clamp_bottom");
        add_row(K_PKT, -256, 255, 1, 0, 0, axil_pkg::RESP_OKAY, 0, "clamp_left");
        add_row(K_PKT, 0, 255, 1, 0, 0, axil_pkg::RESP_OKAY, 0, "clamp_top");
        add_row(K_PKT, 0, 0, 1, 1, 0, axil_pkg::RESP_OKAY, 0, "rand_paint");
        add_row(K_PKT, 0, 0, 1, 1, 0, axil_pkg::RESP_OKAY, 0, "rand_paint_2");
        add_row(K_SWEEP, 0, 0, 0, 0, 0, axil_pkg::RESP_OKAY, 4, "sweep_paint");
        add_row(K_PKT, 0, 0, 0, 1, 0, axil_pkg::RESP_OKAY, 0, "rand_move");
        add_row(K_PKT, 0, 0, 0, 1, 0, axil_pkg::RESP_OKAY, 0, "rand_move_2");
        add_row(K_SWEEP, 0, 0, 0, 0, 0, axil_pkg::RESP_OKAY, 0, "sweep_move");
        add_row(K_BADPAR, 18, 5, 1, 0, 0, axil_pkg::RESP_OKAY, 0, "bad_parity");
        add_row(K_BADHDR, 18, 5, 1, 0, 0, axil_pkg::RESP_OKAY, 0, "bad_header");
        add_row(K_PKT, 16, 32, 1, 0, 0, axil_pkg::RESP_OKAY, 0, "after_corrupt");
        add_row(K_SWEEP, 0, 0, 0, 0, 0, axil_pkg::RESP_OKAY, 0, "sweep_corrupt");
        add_row(K_FRAME, 0, 0, 0, 0, 0, axil_pkg::RESP_OKAY, 0, "frame_check");
        add_row(K_AXWR, 0, 0, 0, 0, 12'h040, axil_pkg::RESP_SLVERR, 4, "wr_bad_addr");
        add_row(K_AXRD, 0, 0, 0, 0, 12'h064, axil_pkg::RESP_SLVERR, 0, "rd_past_end");
        add_row(K_AXRD, 0, 0, 0, 0, 12'h006, axil_pkg::RESP_SLVERR, 5, "rd_unaligned");
        add_row(K_SWEEP, 0, 0, 0, 0, 0, axil_pkg::RESP_OKAY, 0, "sweep_unchanged");
        add_row(K_AXWR, 0, 0, 0, 0, `SKETCH_CLEAR_ADDR, axil_pkg::RESP_OKAY, 3, "clear");
        add_row(K_SWEEP, 0, 0, 0, 0, 0, axil_pkg::RESP_OKAY, 0, "sweep_cleared");

        for (int i = 0; i < n_rows; i++) begin
            if (steps[i].rnd) begin
                steps[i].dx = int'($urandom % 512) - 256;
                steps[i].dy = int'($urandom % 512) - 256;
            end
        end
        limit = n_rows * ROW_BUDGET + 2 * FRAME_CYCLES + 20000;

        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;
        repeat (4) wait_clk();

        for (int i = 0; i < n_rows; i++) apply_row(steps[i]);
        repeat (10) wait_clk();

        $display("Errors: value %0d, other %0d, testbench %0d",
                 value_errs, other_errs, tb_errs);
        if (value_errs + other_errs + tb_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sketch_pad.f
+incdir+include
source/canvas_pkg.sv
source/axil_pkg.sv
source/ps2_mouse_rx.sv
source/cursor_canvas.sv
source/vga_scan_out.sv
source/canvas_axil_slave.sv
source/sketch_pad.sv
sim/sketch_pad_checker.sv
sim/sketch_pad_tb.sv

// File: Bender.yml
package:
  name: sketch_pad

sources:
  - include_dirs:
      - include
    files:
      - source/canvas_pkg.sv
      - source/axil_pkg.sv
      - source/ps2_mouse_rx.sv
      - source/cursor_canvas.sv
      - source/vga_scan_out.sv
      - source/canvas_axil_slave.sv
      - source/sketch_pad.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/sketch_pad_checker.sv
      - sim/sketch_pad_tb.sv
